// File: rtl/task_pkg.sv
`default_nettype none

package task_pkg;

   // Task record fields
   typedef logic [31:0] ts_t;
   typedef logic [31:0] hint_t;
   typedef logic [3:0]  ttype_t;
   typedef logic [31:0] arg_t;

   typedef struct packed {
      ts_t    ts;
      hint_t  hint;
      ttype_t ttype;
      arg_t   arg1;
      arg_t   arg0;
   } task_t;

   // Commit queue side
   typedef logic [6:0] cq_slot_t;
   typedef logic [7:0] child_id_t;

   typedef enum logic [2:0] {
      WAIT_CORE,
      NEXT_TASK,
      INFORM_CQ,
      IO_READ,
      FINISH_TASK,
      FINISH_ABORT,
      ABORT_TASK
   } seq_state_t;

endpackage

`default_nettype wire

// File: rtl/io_map_pkg.sv
`default_nettype none

package io_map_pkg;

   typedef logic [31:0] word_t;
   typedef logic [31:0] io_addr_t;
   typedef logic [7:0]  reg_addr_t;

   // Core I/O window
   localparam io_addr_t IO_DEQ_TASK    = 32'hC000_0000;
   localparam io_addr_t IO_TASK_HINT   = 32'hC000_0004;
   localparam io_addr_t IO_TASK_TTYPE  = 32'hC000_0008;
   localparam io_addr_t IO_TASK_ARG0   = 32'hC000_000C;
   localparam io_addr_t IO_TASK_ARG1   = 32'hC000_0010;
   localparam io_addr_t IO_FINISH_TASK = 32'hC000_0014;
   localparam io_addr_t IO_CUR_CYCLE   = 32'hC000_0018;
   localparam io_addr_t IO_TILE_ID     = 32'hC000_001C;
   localparam io_addr_t IO_CORE_ID     = 32'hC000_0020;

   // Register bus map
   localparam reg_addr_t REG_START      = 8'h00;
   localparam reg_addr_t REG_N_DEQUEUES = 8'h04;
   localparam reg_addr_t REG_NUM_ENQ    = 8'h08;
   localparam reg_addr_t REG_NUM_DEQ    = 8'h0C;
   localparam reg_addr_t REG_STATE      = 8'h10;
   localparam reg_addr_t REG_HINT       = 8'h14;
   localparam reg_addr_t REG_TS         = 8'h18;

   typedef struct packed {
      logic     wr;
      io_addr_t addr;
      word_t    data;
   } core_cmd_t;

   typedef struct packed {
      reg_addr_t addr;
      word_t     data;
   } reg_wr_t;

endpackage

`default_nettype wire

// File: rtl/core_regs.sv
`timescale 1ns/1ps
`default_nettype none

module core_regs #(
   parameter int CORE_ID = 0
) (
   input  wire                    clk,
   input  wire                    rstn,
   input  wire                    reg_wvalid,
   input  io_map_pkg::reg_wr_t    reg_wr,
   input  wire                    reg_arvalid,
   input  io_map_pkg::reg_addr_t  reg_araddr,
   input  wire                    deq_fire,
   input  wire                    enq_fire,
   input  task_pkg::seq_state_t   state,
   input  task_pkg::task_t        cur_task,
   output logic                   start,
   output logic                   budget_ok,
   output logic                   reg_rvalid,
   output io_map_pkg::word_t      reg_rdata
);

   io_map_pkg::word_t budget;
   io_map_pkg::word_t num_enq;
   io_map_pkg::word_t num_deq;

   assign budget_ok = (budget != '0);

   // Each core of the tile owns one bit of the start word
   always_ff @(posedge clk) begin
      if (!rstn) begin
         start <= 1'b0;
      end else if (reg_wvalid && reg_wr.addr == io_map_pkg::REG_START) begin
         start <= reg_wr.data[CORE_ID];
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         budget <= '1;
      end else if (reg_wvalid && reg_wr.addr == io_map_pkg::REG_N_DEQUEUES) begin
         budget <= reg_wr.data;
      end else if (deq_fire) begin
         budget <= budget - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         num_enq <= '0;
         num_deq <= '0;
      end else begin
         if (enq_fire) begin
            num_enq <= num_enq + 1'b1;
         end
         if (deq_fire) begin
            num_deq <= num_deq + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_arvalid) begin
         case (reg_araddr)
            io_map_pkg::REG_START:      reg_rdata <= 32'(start) << CORE_ID;
            io_map_pkg::REG_N_DEQUEUES: reg_rdata <= budget;
            io_map_pkg::REG_NUM_ENQ:    reg_rdata <= num_enq;
            io_map_pkg::REG_NUM_DEQ:    reg_rdata <= num_deq;
            io_map_pkg::REG_STATE:      reg_rdata <= {29'b0, state};
            io_map_pkg::REG_HINT:       reg_rdata <= cur_task.hint;
            io_map_pkg::REG_TS:         reg_rdata <= cur_task.ts;
            default:                    reg_rdata <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rtl/task_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module task_sequencer #(
   parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
   input  wire                    clk,
   input  wire                    rstn,
   input  wire                    deq_req,
   input  wire                    field_req,
   input  wire                    finish_req,
   input  io_map_pkg::io_addr_t   pc,
   input  wire                    start,
   input  wire                    budget_ok,
   input  wire                    task_rvalid,
   input  task_pkg::cq_slot_t     task_rslot,
   input  wire                    start_task_ready,
   input  wire                    finish_task_ready,
   input  wire                    abort_running_task,
   input  wire                    task_wvalid,
   output task_pkg::seq_state_t   state,
   output logic                   abort_pending,
   output logic                   task_arvalid,
   output logic                   deq_fire,
   output logic                   start_task_valid,
   output logic                   finish_task_valid,
   output logic                   finish_done,
   output task_pkg::cq_slot_t     slot,
   output logic                   interrupt
);

   task_pkg::seq_state_t state_next;
   logic                 deq_read;
   logic                 abort_deq;
   logic                 at_reset_pc;

   assign at_reset_pc = (pc == RESET_PC);

   // Dequeue read overtaken by an abort, answered with a finish instead
   assign abort_deq = (state == task_pkg::IO_READ) && deq_read && abort_pending;

   assign task_arvalid = (state == task_pkg::NEXT_TASK) && start && budget_ok
                         && !abort_pending;
   assign deq_fire         = task_arvalid && task_rvalid;
   assign start_task_valid = (state == task_pkg::INFORM_CQ);
   assign interrupt        = (state == task_pkg::FINISH_ABORT)
                             || (state == task_pkg::ABORT_TASK);

   always_comb begin
      finish_task_valid = 1'b0;
      if (state == task_pkg::FINISH_TASK || state == task_pkg::FINISH_ABORT) begin
         // Enqueued children must reach the queue before the finish
         finish_task_valid = !task_wvalid;
      end else if (abort_deq) begin
         finish_task_valid = 1'b1;
      end
   end

   assign finish_done = (state == task_pkg::FINISH_TASK) && finish_task_valid
                        && finish_task_ready;

   always_comb begin
      state_next = state;
      case (state)
         task_pkg::WAIT_CORE: begin
            if (deq_req) begin
               state_next = task_pkg::NEXT_TASK;
            end else if (field_req) begin
               state_next = task_pkg::IO_READ;
            end else if (abort_pending) begin
               state_next = task_pkg::FINISH_ABORT;
            end else if (finish_req) begin
               state_next = task_pkg::FINISH_TASK;
            end
         end
         task_pkg::NEXT_TASK: begin
            if (deq_fire) begin
               state_next = task_pkg::INFORM_CQ;
            end
         end
         task_pkg::INFORM_CQ: begin
            if (start_task_ready) begin
               state_next = task_pkg::IO_READ;
            end
         end
         task_pkg::IO_READ: begin
            if (!abort_deq) begin
               state_next = task_pkg::WAIT_CORE;
            end else if (finish_task_ready) begin
               state_next = task_pkg::NEXT_TASK;
            end
         end
         task_pkg::FINISH_TASK: begin
            if (finish_done) begin
               state_next = task_pkg::WAIT_CORE;
            end
         end
         task_pkg::FINISH_ABORT: begin
            if (finish_task_valid && finish_task_ready) begin
               state_next = task_pkg::ABORT_TASK;
            end
         end
         task_pkg::ABORT_TASK: begin
            if (at_reset_pc) begin
               state_next = task_pkg::WAIT_CORE;
            end
         end
         default: state_next = task_pkg::WAIT_CORE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state         <= task_pkg::WAIT_CORE;
         abort_pending <= 1'b0;
         deq_read      <= 1'b0;
      end else begin
         state <= state_next;
         if (deq_req) begin
            deq_read <= 1'b1;
         end else if (field_req) begin
            deq_read <= 1'b0;
         end
         // An abort racing the finish handshake has nothing left to abort
         if (abort_running_task) begin
            abort_pending <= (state != task_pkg::FINISH_TASK);
         end else if ((state == task_pkg::ABORT_TASK && at_reset_pc)
                      || state_next == task_pkg::NEXT_TASK) begin
            abort_pending <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (deq_fire) begin
         slot <= task_rslot;
      end
   end

endmodule

`default_nettype wire

// File: rtl/core_io_port.sv
`timescale 1ns/1ps
`default_nettype none

module core_io_port #(
   parameter int CORE_ID = 0,
   parameter int TILE_ID = 0
) (
   input  wire                    clk,
   input  wire                    rstn,
   input  wire                    cmd_valid,
   input  io_map_pkg::core_cmd_t  cmd,
   input  task_pkg::seq_state_t   state,
   input  wire                    abort_pending,
   input  wire                    finish_done,
   input  wire                    task_rvalid,
   input  task_pkg::task_t        task_rdata,
   input  wire                    task_wready,
   output logic                   cmd_ready,
   output logic                   rsp_valid,
   output io_map_pkg::word_t      rsp_data,
   output logic                   deq_req,
   output logic                   field_req,
   output logic                   finish_req,
   output logic                   task_wvalid,
   output task_pkg::task_t        task_wdata,
   output logic                   enq_fire,
   output task_pkg::child_id_t    child_id,
   output task_pkg::task_t        cur_task
);

   io_map_pkg::io_addr_t rd_addr;
   io_map_pkg::word_t    cur_cycle;
   logic                 stage_wr;
   logic                 enq_start;
   logic                 rd_take;

   assign stage_wr  = cmd_valid && cmd.wr && !task_wvalid;
   assign enq_start = stage_wr && (cmd.addr == io_map_pkg::IO_DEQ_TASK) && !abort_pending;
   assign rd_take   = cmd_valid && !cmd.wr && (state == task_pkg::WAIT_CORE)
                      && !abort_pending;
   assign enq_fire  = task_wvalid && task_wready;

   always_comb begin
      cmd_ready  = 1'b0;
      deq_req    = 1'b0;
      field_req  = 1'b0;
      finish_req = 1'b0;
      if (cmd_valid && cmd.wr) begin
         case (cmd.addr)
            io_map_pkg::IO_FINISH_TASK: begin
               finish_req = 1'b1;
               cmd_ready  = finish_done;
            end
            io_map_pkg::IO_DEQ_TASK,
            io_map_pkg::IO_TASK_HINT,
            io_map_pkg::IO_TASK_TTYPE,
            io_map_pkg::IO_TASK_ARG0,
            io_map_pkg::IO_TASK_ARG1: cmd_ready = !task_wvalid;
            default: cmd_ready = 1'b1;
         endcase
      end else if (rd_take) begin
         // Reads are taken only in WAIT_CORE with no abort pending
         cmd_ready = 1'b1;
         deq_req   = (cmd.addr == io_map_pkg::IO_DEQ_TASK);
         field_req = (cmd.addr != io_map_pkg::IO_DEQ_TASK);
      end
   end

   // Staging record doubles as the enqueue payload
   always_ff @(posedge clk) begin
      if (stage_wr) begin
         case (cmd.addr)
            io_map_pkg::IO_DEQ_TASK:   task_wdata.ts    <= cmd.data;
            io_map_pkg::IO_TASK_HINT:  task_wdata.hint  <= cmd.data;
            io_map_pkg::IO_TASK_TTYPE: task_wdata.ttype <= cmd.data[3:0];
            io_map_pkg::IO_TASK_ARG0:  task_wdata.arg0  <= cmd.data;
            io_map_pkg::IO_TASK_ARG1:  task_wdata.arg1  <= cmd.data;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_wvalid <= 1'b0;
      end else if (enq_start) begin
         task_wvalid <= 1'b1;
      end else if (task_wready || state == task_pkg::FINISH_ABORT) begin
         // Aborted task loses its pending child
         task_wvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         child_id  <= '0;
         cur_cycle <= '0;
      end else begin
         cur_cycle <= cur_cycle + 1'b1;
         if (state == task_pkg::NEXT_TASK) begin
            child_id <= '0;
         end else if (enq_fire) begin
            child_id <= child_id + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == task_pkg::NEXT_TASK && task_rvalid) begin
         cur_task <= task_rdata;
      end
      if (rd_take) begin
         rd_addr <= cmd.addr;
      end
   end

   // Dequeue reply is held back while an abort is pending
   assign rsp_valid = (state == task_pkg::IO_READ)
                      && !(rd_addr == io_map_pkg::IO_DEQ_TASK && abort_pending);

   always_comb begin
      case (rd_addr)
         io_map_pkg::IO_DEQ_TASK:   rsp_data = cur_task.ts;
         io_map_pkg::IO_TASK_HINT:  rsp_data = cur_task.hint;
         io_map_pkg::IO_TASK_TTYPE: rsp_data = {28'b0, cur_task.ttype};
         io_map_pkg::IO_TASK_ARG0:  rsp_data = cur_task.arg0;
         io_map_pkg::IO_TASK_ARG1:  rsp_data = cur_task.arg1;
         io_map_pkg::IO_CUR_CYCLE:  rsp_data = cur_cycle;
         io_map_pkg::IO_TILE_ID:    rsp_data = 32'(TILE_ID);
         io_map_pkg::IO_CORE_ID:    rsp_data = 32'(CORE_ID);
         default:                   rsp_data = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/task_unit.sv
`timescale 1ns/1ps
`default_nettype none

module task_unit #(
   parameter int          CORE_ID  = 0,
   parameter int          TILE_ID  = 0,
   parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
   input  wire                        clk,
   input  wire                        rstn,

   // Core data bus
   input  wire                        cmd_valid,
   input  io_map_pkg::core_cmd_t      cmd,
   output logic                       cmd_ready,
   output logic                       rsp_valid,
   output io_map_pkg::word_t          rsp_data,
   input  io_map_pkg::io_addr_t       pc,

   // Dequeue
   output logic                       task_arvalid,
   input  wire                        task_rvalid,
   input  task_pkg::task_t            task_rdata,
   input  task_pkg::cq_slot_t         task_rslot,

   output logic                       start_task_valid,
   output task_pkg::cq_slot_t         start_task_slot,
   input  wire                        start_task_ready,

   // Enqueue
   output logic                       task_wvalid,
   output task_pkg::task_t            task_wdata,
   input  wire                        task_wready,
   output task_pkg::child_id_t        task_child_id,

   // Finish
   output logic                       finish_task_valid,
   output task_pkg::cq_slot_t         finish_task_slot,
   output task_pkg::child_id_t        finish_task_num_children,
   input  wire                        finish_task_ready,

   input  wire                        abort_running_task,
   output logic                       interrupt,

   // Register bus
   input  wire                        reg_wvalid,
   input  io_map_pkg::reg_wr_t        reg_wr,
   input  wire                        reg_arvalid,
   input  io_map_pkg::reg_addr_t      reg_araddr,
   output logic                       reg_rvalid,
   output io_map_pkg::word_t          reg_rdata
);

   logic                    start;
   logic                    budget_ok;
   logic                    deq_fire;
   logic                    enq_fire;
   logic                    abort_pending;
   logic                    finish_done;
   logic                    deq_req;
   logic                    field_req;
   logic                    finish_req;
   task_pkg::seq_state_t    state;
   task_pkg::cq_slot_t      slot;
   task_pkg::child_id_t     child_id;
   task_pkg::task_t         cur_task;

   assign start_task_slot          = slot;
   assign finish_task_slot         = slot;
   assign task_child_id            = child_id;
   assign finish_task_num_children = child_id;

   core_regs #(
      .CORE_ID (CORE_ID)
   ) i_core_regs (
      .clk         (clk),
      .rstn        (rstn),
      .reg_wvalid  (reg_wvalid),
      .reg_wr      (reg_wr),
      .reg_arvalid (reg_arvalid),
      .reg_araddr  (reg_araddr),
      .deq_fire    (deq_fire),
      .enq_fire    (enq_fire),
      .state       (state),
      .cur_task    (cur_task),
      .start       (start),
      .budget_ok   (budget_ok),
      .reg_rvalid  (reg_rvalid),
      .reg_rdata   (reg_rdata)
   );

   task_sequencer #(
      .RESET_PC (RESET_PC)
   ) i_task_sequencer (
      .clk                (clk),
      .rstn               (rstn),
      .deq_req            (deq_req),
      .field_req          (field_req),
      .finish_req         (finish_req),
      .pc                 (pc),
      .start              (start),
      .budget_ok          (budget_ok),
      .task_rvalid        (task_rvalid),
      .task_rslot         (task_rslot),
      .start_task_ready   (start_task_ready),
      .finish_task_ready  (finish_task_ready),
      .abort_running_task (abort_running_task),
      .task_wvalid        (task_wvalid),
      .state              (state),
      .abort_pending      (abort_pending),
      .task_arvalid       (task_arvalid),
      .deq_fire           (deq_fire),
      .start_task_valid   (start_task_valid),
      .finish_task_valid  (finish_task_valid),
      .finish_done        (finish_done),
      .slot               (slot),
      .interrupt          (interrupt)
   );

   core_io_port #(
      .CORE_ID (CORE_ID),
      .TILE_ID (TILE_ID)
   ) i_core_io_port (
      .clk           (clk),
      .rstn          (rstn),
      .cmd_valid     (cmd_valid),
      .cmd           (cmd),
      .state         (state),
      .abort_pending (abort_pending),
      .finish_done   (finish_done),
      .task_rvalid   (task_rvalid),
      .task_rdata    (task_rdata),
      .task_wready   (task_wready),
      .cmd_ready     (cmd_ready),
      .rsp_valid     (rsp_valid),
      .rsp_data      (rsp_data),
      .deq_req       (deq_req),
      .field_req     (field_req),
      .finish_req    (finish_req),
      .task_wvalid   (task_wvalid),
      .task_wdata    (task_wdata),
      .enq_fire      (enq_fire),
      .child_id      (child_id),
      .cur_task      (cur_task)
   );

endmodule

`default_nettype wire

// File: bench/tb_task_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_task_unit;

   localparam int                   CORE_ID  = 1;
   localparam int                   TILE_ID  = 3;
   localparam logic [31:0]          RESET_PC = 32'h8000_0000;
   localparam io_map_pkg::io_addr_t RUN_PC   = 32'h8000_0100;
   localparam int                   TIMEOUT  = 200;

   logic                       clk;
   logic                       rstn;
   logic                       cmd_valid;
   io_map_pkg::core_cmd_t      cmd;
   logic                       cmd_ready;
   logic                       rsp_valid;
   io_map_pkg::word_t          rsp_data;
   io_map_pkg::io_addr_t       pc;
   logic                       task_arvalid;
   logic                       task_rvalid;
   task_pkg::task_t            task_rdata;
   task_pkg::cq_slot_t         task_rslot;
   logic                       start_task_valid;
   task_pkg::cq_slot_t         start_task_slot;
   logic                       start_task_ready;
   logic                       task_wvalid;
   task_pkg::task_t            task_wdata;
   logic                       task_wready;
   task_pkg::child_id_t        task_child_id;
   logic                       finish_task_valid;
   task_pkg::cq_slot_t         finish_task_slot;
   task_pkg::child_id_t        finish_task_num_children;
   logic                       finish_task_ready;
   logic                       abort_running_task;
   logic                       interrupt;
   logic                       reg_wvalid;
   io_map_pkg::reg_wr_t        reg_wr;
   logic                       reg_arvalid;
   io_map_pkg::reg_addr_t      reg_araddr;
   logic                       reg_rvalid;
   io_map_pkg::word_t          reg_rdata;

   // Tasks at 0 and 6, children at 12 and 17, delays at 22..24, budget at 25
   logic [31:0] tdata [0:25];
   integer      seed;

   task_unit #(
      .CORE_ID  (CORE_ID),
      .TILE_ID  (TILE_ID),
      .RESET_PC (RESET_PC)
   ) i_task_unit (.*);

   always #20 clk = ~clk;

   task automatic fail_run(input string line);
      $display("%s", line);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic check_value(input string what, input logic [191:0] got,
                              input logic [191:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp));
      end
   endtask

   function automatic logic sig_value(input string name);
      return (name == "task_arvalid")      ? task_arvalid :
             (name == "start_task_valid")  ? start_task_valid :
             (name == "task_wvalid")       ? task_wvalid :
             (name == "finish_task_valid") ? finish_task_valid :
             (name == "rsp_valid")         ? rsp_valid :
             (name == "interrupt")         ? interrupt : 1'bx;
   endfunction

   // Returns just after the clock edge that saw the signal at the level
   task automatic wait_level(input string name, input logic level);
      int n;
      n = 0;
      @(posedge clk);
      while (sig_value(name) !== level) begin
         n++;
         if (n >= TIMEOUT) begin
            fail_run($sformatf("Timeout while waiting for %s to become %0b", name, level));
         end
         @(posedge clk);
      end
   endtask

   task automatic reg_write(input io_map_pkg::reg_addr_t addr, input io_map_pkg::word_t data);
      @(negedge clk);
      reg_wvalid  = 1'b1;
      reg_wr.addr = addr;
      reg_wr.data = data;
      @(negedge clk);
      reg_wvalid = 1'b0;
   endtask

   task automatic reg_check(input io_map_pkg::reg_addr_t addr, input io_map_pkg::word_t exp,
                            input string what);
      @(negedge clk);
      reg_arvalid = 1'b1;
      reg_araddr  = addr;
      @(posedge clk);
      check_value({what, " reg_rvalid too early"}, reg_rvalid, 0);
      @(negedge clk);
      reg_arvalid = 1'b0;
      @(posedge clk);
      check_value({what, " reg_rvalid"}, reg_rvalid, 1);
      check_value(what, reg_rdata, exp);
   endtask

   task automatic core_cmd(input logic wr, input io_map_pkg::io_addr_t addr,
                           input io_map_pkg::word_t data);
      int n;
      n = 0;
      @(negedge clk);
      cmd_valid = 1'b1;
      cmd.wr    = wr;
      cmd.addr  = addr;
      cmd.data  = data;
      @(posedge clk);
      while (!cmd_ready) begin
         n++;
         if (n >= TIMEOUT) begin
            fail_run($sformatf("Timeout while the core command to %h was not taken", addr));
         end
         @(posedge clk);
      end
      @(negedge clk);
      cmd_valid = 1'b0;
   endtask

   // Single-cycle reads answer in the cycle after the take
   task automatic core_read(input io_map_pkg::io_addr_t addr, output io_map_pkg::word_t data);
      core_cmd(1'b0, addr, '0);
      @(posedge clk);
      check_value($sformatf("rsp_valid for read of %h", addr), rsp_valid, 1);
      data = rsp_data;
   endtask

   task automatic field_check(input io_map_pkg::io_addr_t addr, input io_map_pkg::word_t exp,
                              input string what);
      io_map_pkg::word_t data;
      core_read(addr, data);
      check_value(what, data, exp);
   endtask

   task automatic dequeue_task(input int k);
      task_pkg::task_t t;
      int              base;
      base    = 6 * k;
      t.ts    = tdata[base];
      t.hint  = tdata[base + 1];
      t.ttype = tdata[base + 2][3:0];
      t.arg0  = tdata[base + 3];
      t.arg1  = tdata[base + 4];
      core_cmd(1'b0, io_map_pkg::IO_DEQ_TASK, '0);
      wait_level("task_arvalid", 1'b1);
      repeat (tdata[22]) @(negedge clk);
      @(negedge clk);
      task_rvalid = 1'b1;
      task_rdata  = t;
      task_rslot  = tdata[base + 5][6:0];
      @(posedge clk);
      check_value("task_arvalid at transfer", task_arvalid, 1);
      @(negedge clk);
      task_rvalid = 1'b0;
      wait_level("start_task_valid", 1'b1);
      check_value("start_task_slot", start_task_slot, tdata[base + 5]);
      repeat (tdata[23]) @(negedge clk);
      @(negedge clk);
      start_task_ready = 1'b1;
      @(posedge clk);
      check_value("start_task_valid at handshake", start_task_valid, 1);
      @(negedge clk);
      start_task_ready = 1'b0;
      wait_level("rsp_valid", 1'b1);
      check_value("dequeue response timestamp", rsp_data, t.ts);
   endtask

   task automatic enqueue_child(input int c);
      task_pkg::task_t exp;
      int              base;
      int              stall;
      base      = 12 + 5 * c;
      exp.ts    = tdata[base];
      exp.hint  = tdata[base + 1];
      exp.ttype = tdata[base + 2][3:0];
      exp.arg0  = tdata[base + 3];
      exp.arg1  = tdata[base + 4];
      core_cmd(1'b1, io_map_pkg::IO_TASK_HINT, tdata[base + 1]);
      core_cmd(1'b1, io_map_pkg::IO_TASK_TTYPE, tdata[base + 2]);
      core_cmd(1'b1, io_map_pkg::IO_TASK_ARG0, tdata[base + 3]);
      core_cmd(1'b1, io_map_pkg::IO_TASK_ARG1, tdata[base + 4]);
      core_cmd(1'b1, io_map_pkg::IO_DEQ_TASK, tdata[base]);
      wait_level("task_wvalid", 1'b1);
      check_value("task_wdata", task_wdata, exp);
      stall = {$random(seed)} % 5;
      repeat (stall) begin
         @(posedge clk);
         check_value("task_wvalid during stall", task_wvalid, 1);
         check_value("task_wdata during stall", task_wdata, exp);
      end
      @(negedge clk);
      task_wready = 1'b1;
      @(posedge clk);
      check_value("task_wvalid at handshake", task_wvalid, 1);
      check_value("task_child_id", task_child_id, c);
      @(negedge clk);
      task_wready = 1'b0;
      check_value("task_wvalid after handshake", task_wvalid, 0);
   endtask

   task automatic finish_current(input logic [31:0] exp_slot, input int children);
      @(negedge clk);
      cmd_valid = 1'b1;
      cmd.wr    = 1'b1;
      cmd.addr  = io_map_pkg::IO_FINISH_TASK;
      cmd.data  = '0;
      wait_level("finish_task_valid", 1'b1);
      check_value("cmd_ready before finish ready", cmd_ready, 0);
      repeat (tdata[24]) begin
         @(posedge clk);
         check_value("cmd_ready while finish stalls", cmd_ready, 0);
      end
      @(negedge clk);
      finish_task_ready = 1'b1;
      @(posedge clk);
      check_value("cmd_ready at finish", cmd_ready, 1);
      check_value("finish_task_valid at handshake", finish_task_valid, 1);
      check_value("finish_task_slot", finish_task_slot, exp_slot);
      check_value("finish_task_num_children", finish_task_num_children, children);
      @(negedge clk);
      finish_task_ready = 1'b0;
      cmd_valid         = 1'b0;
   endtask

   initial begin
      io_map_pkg::word_t c1;
      io_map_pkg::word_t c2;
      int                n;
      seed               = 56;
      clk                = 1'b0;
      rstn               = 1'b0;
      cmd_valid          = 1'b0;
      cmd                = '0;
      pc                 = RUN_PC;
      task_rvalid        = 1'b0;
      task_rdata         = '0;
      task_rslot         = '0;
      start_task_ready   = 1'b0;
      task_wready        = 1'b0;
      finish_task_ready  = 1'b0;
      abort_running_task = 1'b0;
      reg_wvalid         = 1'b0;
      reg_wr             = '0;
      reg_arvalid        = 1'b0;
      reg_araddr         = '0;
      $readmemh("bench/task_unit_testdata.txt", tdata);
      repeat (4) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      @(posedge clk);
      check_value("control outputs after reset",
                  {task_arvalid, task_wvalid, start_task_valid, finish_task_valid,
                   rsp_valid, reg_rvalid, interrupt}, 0);

      // Register bus and dequeue budget
      reg_check(io_map_pkg::REG_N_DEQUEUES, 32'hFFFF_FFFF, "budget after reset");
      reg_write(io_map_pkg::REG_N_DEQUEUES, tdata[25]);
      reg_check(io_map_pkg::REG_N_DEQUEUES, tdata[25], "budget after write");
      reg_write(io_map_pkg::REG_START, 32'(1) << CORE_ID);
      reg_check(io_map_pkg::REG_START, 32'(1) << CORE_ID, "start word");

      dequeue_task(0);
      field_check(io_map_pkg::IO_TASK_HINT, tdata[1], "hint read");
      field_check(io_map_pkg::IO_TASK_TTYPE, tdata[2], "type read");
      field_check(io_map_pkg::IO_TASK_ARG0, tdata[3], "arg0 read");
      field_check(io_map_pkg::IO_TASK_ARG1, tdata[4], "arg1 read");
      field_check(io_map_pkg::IO_TILE_ID, TILE_ID, "tile id read");
      field_check(io_map_pkg::IO_CORE_ID, CORE_ID, "core id read");
      field_check(32'hC000_0100, 0, "unmapped read");
      core_read(io_map_pkg::IO_CUR_CYCLE, c1);
      core_read(io_map_pkg::IO_CUR_CYCLE, c2);
      check_value("cycle counter step", c2 - c1, 2);
      reg_check(io_map_pkg::REG_TS, tdata[0], "current timestamp");
      reg_check(io_map_pkg::REG_HINT, tdata[1], "current hint");

      enqueue_child(0);
      enqueue_child(1);
      reg_check(io_map_pkg::REG_NUM_ENQ, 2, "enqueue count");

      finish_current(tdata[5], 2);

      // Abort from WAIT_CORE finishes the old slot, then waits for the reset vector
      @(negedge clk);
      abort_running_task = 1'b1;
      @(negedge clk);
      abort_running_task = 1'b0;
      wait_level("interrupt", 1'b1);
      check_value("finish_task_valid on abort", finish_task_valid, 1);
      check_value("finish_task_slot on abort", finish_task_slot, tdata[5]);
      @(negedge clk);
      finish_task_ready = 1'b1;
      @(posedge clk);
      check_value("finish_task_valid at abort handshake", finish_task_valid, 1);
      @(negedge clk);
      finish_task_ready = 1'b0;
      repeat (3) begin
         @(posedge clk);
         check_value("interrupt before reset vector", interrupt, 1);
      end
      @(negedge clk);
      pc = RESET_PC;
      wait_level("interrupt", 1'b0);
      @(negedge clk);
      pc = RUN_PC;
      reg_check(io_map_pkg::REG_STATE, task_pkg::WAIT_CORE, "state after abort");

      dequeue_task(1);
      field_check(io_map_pkg::IO_TASK_ARG1, tdata[10], "arg1 read of second task");

      // Budget used up, so the queue is never asked again
      reg_check(io_map_pkg::REG_N_DEQUEUES, 0, "budget used up");
      core_cmd(1'b0, io_map_pkg::IO_DEQ_TASK, '0);
      n = 0;
      while (n < TIMEOUT) begin
         @(posedge clk);
         check_value("task_arvalid without budget", task_arvalid, 0);
         n++;
      end
      reg_check(io_map_pkg::REG_NUM_DEQ, tdata[25], "dequeue count");

      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

// File: bench/task_unit_testdata.txt
// Dequeued tasks, one per line: ts hint ttype arg0 arg1 slot
00000100 1234abcd 00000005 a5a50001 5a5a0002 00000011
00000180 0badcafe 0000000c 12345678 87654321 0000006a
// Children enqueued by the first task: ts hint ttype arg0 arg1
00000140 00c0ffee 00000003 00000010 00000020
00000160 deadbeef 0000000f ffffffff 00000000
// Ready delays in cycles: task_rvalid start_task_ready finish_task_ready
00000002 00000003 00000004
// Dequeue budget written over the register bus
00000002

// File: vlog.f
rtl/task_pkg.sv
rtl/io_map_pkg.sv
rtl/core_regs.sv
rtl/task_sequencer.sv
rtl/core_io_port.sv
rtl/task_unit.sv
bench/tb_task_unit.sv

// File: Makefile
TOOL     = verilator
TOP      = tb_task_unit
FILELIST = vlog.f
FLAGS    = --binary --timing -Wno-fatal
BUILD    = obj_dir
LOG      = sim.log
PASS     = NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS)" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
